// File: Makefile
# Verilator build, run and lint for the decode front end

VERILATOR ?= verilator
TOP       ?= decode_tb
RTL_TOP   ?= decode_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
LINTFLAGS ?= --lint-only -Wall --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: project.f
+incdir+tests
source/decode_pkg.sv
source/mem_pkg.sv
source/mem_bus_if.sv
source/offset_selector.sv
source/insn_fetch.sv
source/operand_fetch.sv
source/shared_memory.sv
source/decode_unit.sv
source/decode_top.sv
tests/decode_tb.sv

// File: source/decode_pkg.sv
// Instruction decode types
`default_nettype none

package decode_pkg;

    // one 16-byte line, byte 0 in bits 127:120
    typedef logic [127:0] insn_line_t;

    typedef logic [2:0] off_sel_t;

    typedef enum logic [1:0] {
        SIZE_1 = 2'd0,
        SIZE_2 = 2'd1,
        SIZE_4 = 2'd2,
        SIZE_6 = 2'd3
    } field_size_t;

    // codes 4 to 7 decode as halt
    typedef enum logic [2:0] {
        OP_HALT = 3'd0,
        OP_IMM  = 3'd1,
        OP_LOAD = 3'd2,
        OP_FAR  = 3'd3
    } op_class_t;

    typedef struct packed {
        off_sel_t    off_sel;
        field_size_t size;
        op_class_t   op_class;
    } insn_header_t;

    typedef struct packed {
        logic [15:0] selector;
        logic [31:0] offset;
    } far_ptr_t;

    // raw view for immediates and displacements, split view for far pointers
    typedef union packed {
        logic [47:0] raw;
        far_ptr_t    far;
    } field_t;

    typedef enum logic [1:0] {
        RES_IMM  = 2'd0,
        RES_LOAD = 2'd1,
        RES_FAR  = 2'd2
    } result_kind_t;

endpackage

`default_nettype wire

// File: source/decode_top.sv
// Decode front end top level
`timescale 1ns/1ps
`default_nettype none

module decode_top #(
    parameter int MEM_LINES = 256
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  mem_pkg::line_addr_t      start_line,
    input  logic                     load_en,
    input  mem_pkg::line_addr_t      load_addr,
    input  mem_pkg::line_t           load_data,
    output logic                     result_valid,
    output decode_pkg::result_kind_t result_kind,
    output decode_pkg::field_t       result_value,
    output logic                     halted
);
    import decode_pkg::*;
    import mem_pkg::*;

    logic       line_valid;
    logic       consume;
    logic       halt_seen;
    logic       op_start;
    logic       op_done;
    insn_line_t insn_line;
    field_t     disp;
    word_t      op_word;

    mem_bus_if fetch_bus ();
    mem_bus_if opnd_bus ();

    insn_fetch u_insn_fetch (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .start_line (start_line),
        .halt_seen  (halt_seen),
        .consume    (consume),
        .bus        (fetch_bus.requester),
        .line_valid (line_valid),
        .line       (insn_line)
    );

    operand_fetch u_operand_fetch (
        .clk      (clk),
        .reset    (reset),
        .op_start (op_start),
        .disp     (disp),
        .bus      (opnd_bus.requester),
        .op_done  (op_done),
        .op_word  (op_word)
    );

    shared_memory #(
        .MEM_LINES (MEM_LINES)
    ) u_shared_memory (
        .clk       (clk),
        .reset     (reset),
        .opnd      (opnd_bus.arbiter),
        .fetch     (fetch_bus.arbiter),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

    decode_unit u_decode_unit (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .line_valid   (line_valid),
        .line         (insn_line),
        .op_done      (op_done),
        .op_word      (op_word),
        .consume      (consume),
        .halt_seen    (halt_seen),
        .op_start     (op_start),
        .disp         (disp),
        .result_valid (result_valid),
        .result_kind  (result_kind),
        .result_value (result_value),
        .halted       (halted)
    );

endmodule

`default_nettype wire

// File: source/decode_unit.sv
// Instruction decode and dispatch
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  logic                     line_valid,
    input  decode_pkg::insn_line_t   line,
    input  logic                     op_done,
    input  mem_pkg::word_t           op_word,
    output logic                     consume,
    output logic                     halt_seen,
    output logic                     op_start,
    output decode_pkg::field_t       disp,
    output logic                     result_valid,
    output decode_pkg::result_kind_t result_kind,
    output decode_pkg::field_t       result_value,
    output logic                     halted
);
    import decode_pkg::*;

    typedef enum logic {
        S_DECODE  = 1'b0,
        S_WAIT_OP = 1'b1
    } state_t;

    state_t       state;
    insn_header_t hdr;
    field_t       field;
    logic         take;

    assign hdr = insn_header_t'(line[127:120]);

    offset_selector u_offset_selector (
        .line    (line),
        .off_sel (hdr.off_sel),
        .size    (hdr.size),
        .field   (field)
    );

    // line still shows valid in the consume cycle, skip it there
    assign take = line_valid && (state == S_DECODE) && !consume && !halted;

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= S_DECODE;
            consume      <= 1'b0;
            halt_seen    <= 1'b0;
            op_start     <= 1'b0;
            result_valid <= 1'b0;
            halted       <= 1'b0;
        end else begin
            consume      <= 1'b0;
            halt_seen    <= 1'b0;
            op_start     <= 1'b0;
            result_valid <= 1'b0;
            if (start) begin
                state  <= S_DECODE;
                halted <= 1'b0;
            end else if (take) begin
                case (hdr.op_class)
                    OP_IMM, OP_FAR: begin
                        result_valid <= 1'b1;
                        consume      <= 1'b1;
                    end
                    OP_LOAD: begin
                        op_start <= 1'b1;
                        state    <= S_WAIT_OP;
                    end
                    default: begin
                        halt_seen <= 1'b1;
                        consume   <= 1'b1;
                        halted    <= 1'b1;
                    end
                endcase
            end else if ((state == S_WAIT_OP) && op_done) begin
                result_valid <= 1'b1;
                consume      <= 1'b1;
                state        <= S_DECODE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            disp <= field;
            if (hdr.op_class == OP_IMM) begin
                result_kind      <= RES_IMM;
                result_value.raw <= field.raw;
            end else if (hdr.op_class == OP_FAR) begin
                result_kind               <= RES_FAR;
                result_value.far.selector <= field.far.selector;
                result_value.far.offset   <= field.far.offset;
            end
        end else if (op_done) begin
            // loaded word zero-extended
            result_kind      <= RES_LOAD;
            result_value.raw <= 48'(op_word);
        end
    end

    a_done_only_when_waiting: assert property (
        @(posedge clk) disable iff (reset) op_done |-> state == S_WAIT_OP
    );

endmodule

`default_nettype wire

// File: source/insn_fetch.sv
// Instruction line fetcher
`timescale 1ns/1ps
`default_nettype none

module insn_fetch (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  mem_pkg::line_addr_t    start_line,
    input  logic                   halt_seen,
    input  logic                   consume,
    mem_bus_if.requester           bus,
    output logic                   line_valid,
    output decode_pkg::insn_line_t line
);
    import mem_pkg::*;
    import decode_pkg::*;

    logic       running;
    logic       inflight;
    line_addr_t next_line;
    logic [1:0] slot_valid;
    logic [1:0] slot_valid_n;
    insn_line_t slot_line [2];
    insn_line_t slot_line_n [2];
    logic [1:0] occupancy;

    // a granted read holds its slot until the data lands
    assign occupancy = 2'(slot_valid[0]) + 2'(slot_valid[1]) + 2'(inflight);

    assign bus.req  = running && !halt_seen && (occupancy < 2'd2);
    assign bus.addr = next_line;

    assign line_valid = slot_valid[0];
    assign line       = slot_line[0];

    always_comb begin
        slot_valid_n = slot_valid;
        slot_line_n  = slot_line;
        if (consume) begin
            slot_valid_n   = {1'b0, slot_valid[1]};
            slot_line_n[0] = slot_line[1];
        end
        if (bus.rvalid) begin
            if (!slot_valid_n[0]) begin
                slot_valid_n[0] = 1'b1;
                slot_line_n[0]  = bus.rdata;
            end else begin
                slot_valid_n[1] = 1'b1;
                slot_line_n[1]  = bus.rdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            running    <= 1'b0;
            inflight   <= 1'b0;
            next_line  <= '0;
            slot_valid <= '0;
        end else if (start) begin
            running    <= 1'b1;
            inflight   <= 1'b0;
            next_line  <= start_line;
            slot_valid <= '0;
        end else if (halt_seen) begin
            // late read data this cycle is dropped with the queue
            running    <= 1'b0;
            inflight   <= 1'b0;
            slot_valid <= '0;
        end else begin
            inflight   <= bus.grant;
            slot_valid <= slot_valid_n;
            if (bus.grant) begin
                next_line <= next_line + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        slot_line <= slot_line_n;
    end

    a_consume_needs_line: assert property (
        @(posedge clk) disable iff (reset) consume |-> line_valid
    );

endmodule

`default_nettype wire

// File: source/mem_bus_if.sv
// Memory request bus
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if;
    import mem_pkg::*;

    logic       req;
    line_addr_t addr;
    logic       grant;
    logic       rvalid;
    line_t      rdata;

    modport requester (
        output req,
        output addr,
        input  grant,
        input  rvalid,
        input  rdata
    );

    modport arbiter (
        input  req,
        input  addr,
        output grant,
        output rvalid,
        output rdata
    );

endinterface

`default_nettype wire

// File: source/mem_pkg.sv
// Shared memory geometry
`default_nettype none

package mem_pkg;

    localparam int ADDR_BITS      = 8;
    localparam int LINE_BITS      = 128;
    localparam int WORD_BITS      = 32;
    localparam int WORDS_PER_LINE = LINE_BITS / WORD_BITS;

    typedef logic [ADDR_BITS-1:0] line_addr_t;
    typedef logic [LINE_BITS-1:0] line_t;
    typedef logic [WORD_BITS-1:0] word_t;

    // operand side wins arbitration
    typedef enum logic {
        REQ_OPND  = 1'b0,
        REQ_FETCH = 1'b1
    } requester_t;

endpackage

`default_nettype wire

// File: source/offset_selector.sv
// Instruction field extractor
`timescale 1ns/1ps
`default_nettype none

module offset_selector (
    input  decode_pkg::insn_line_t  line,
    input  decode_pkg::off_sel_t    off_sel,
    input  decode_pkg::field_size_t size,
    output decode_pkg::field_t      field
);
    import decode_pkg::*;

    logic [7:0] line_bytes [16];
    logic [3:0] start_byte;
    logic [2:0] byte_count;

    always_comb begin
        for (int i = 0; i < 16; i++) begin
            line_bytes[i] = line[127 - 8*i -: 8];
        end
    end

    always_comb begin
        case (off_sel)
            3'd4:    start_byte = 4'd5;
            3'd5:    start_byte = 4'd2;
            3'd6:    start_byte = 4'd3;
            3'd7:    start_byte = 4'd4;
            default: start_byte = 4'd6;
        endcase
    end

    always_comb begin
        case (size)
            SIZE_1:  byte_count = 3'd1;
            SIZE_2:  byte_count = 3'd2;
            SIZE_4:  byte_count = 3'd4;
            default: byte_count = 3'd6;
        endcase
    end

    // field byte k comes from line byte start+k, bytes past the size read zero
    always_comb begin
        field.raw = '0;
        for (int k = 0; k < 6; k++) begin
            if (3'(k) < byte_count) begin
                field.raw[8*k +: 8] = line_bytes[start_byte + 4'(k)];
            end
        end
    end

endmodule

`default_nettype wire

// File: source/operand_fetch.sv
// Data word reader
`timescale 1ns/1ps
`default_nettype none

module operand_fetch (
    input  logic               clk,
    input  logic               reset,
    input  logic               op_start,
    input  decode_pkg::field_t disp,
    mem_bus_if.requester       bus,
    output logic               op_done,
    output mem_pkg::word_t     op_word
);
    import mem_pkg::*;

    typedef enum logic {
        S_IDLE = 1'b0,
        S_BUSY = 1'b1
    } state_t;

    state_t                              state;
    logic                                rd_pending;
    line_addr_t                          line_sel;
    logic [$clog2(WORDS_PER_LINE)-1:0]   word_sel;

    // drop req once granted, data follows next cycle
    assign bus.req  = (state == S_BUSY) && !rd_pending;
    assign bus.addr = line_sel;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= S_IDLE;
            rd_pending <= 1'b0;
            op_done    <= 1'b0;
        end else begin
            op_done    <= 1'b0;
            rd_pending <= bus.grant;
            case (state)
                S_IDLE: begin
                    if (op_start) begin
                        state <= S_BUSY;
                    end
                end
                default: begin
                    if (rd_pending && bus.rvalid) begin
                        state   <= S_IDLE;
                        op_done <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (op_start) begin
            line_sel <= disp.raw[7:0];
            word_sel <= disp.raw[9:8];
        end
        // word 0 sits in the low bits of the line
        if (bus.rvalid) begin
            op_word <= bus.rdata[WORD_BITS*word_sel +: WORD_BITS];
        end
    end

    a_no_start_while_busy: assert property (
        @(posedge clk) disable iff (reset) op_start |-> state == S_IDLE
    );

endmodule

`default_nettype wire

// File: source/shared_memory.sv
// Arbitrated line memory
`timescale 1ns/1ps
`default_nettype none

module shared_memory #(
    parameter int MEM_LINES = 256
) (
    input  logic                clk,
    input  logic                reset,
    mem_bus_if.arbiter          opnd,
    mem_bus_if.arbiter          fetch,
    input  logic                load_en,
    input  mem_pkg::line_addr_t load_addr,
    input  mem_pkg::line_t      load_data
);
    import mem_pkg::*;

    line_t      mem [MEM_LINES];
    line_t      rdata_q;
    logic       rd_valid;
    requester_t rd_owner;

    // fixed priority, operand first
    assign opnd.grant  = opnd.req;
    assign fetch.grant = fetch.req && !opnd.req;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
            rd_owner <= REQ_OPND;
        end else begin
            rd_valid <= opnd.grant || fetch.grant;
            rd_owner <= opnd.req ? REQ_OPND : REQ_FETCH;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
        if (opnd.grant) begin
            rdata_q <= mem[opnd.addr];
        end else if (fetch.grant) begin
            rdata_q <= mem[fetch.addr];
        end
    end

    assign opnd.rvalid  = rd_valid && (rd_owner == REQ_OPND);
    assign fetch.rvalid = rd_valid && (rd_owner == REQ_FETCH);
    assign opnd.rdata   = rdata_q;
    assign fetch.rdata  = rdata_q;

    // memory is loaded only while both requesters are quiet
    a_load_while_idle: assert property (
        @(posedge clk) disable iff (reset) load_en |-> !(opnd.req || fetch.req)
    );

endmodule

`default_nettype wire

// File: tests/decode_model.svh
// Decode reference model
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// copy of every line written through the load port
line_t model_mem [256];

function automatic logic [7:0] line_byte(input line_t l, input int n);
    return l[127 - 8*n -: 8];
endfunction

function automatic int start_of(input logic [2:0] sel);
    case (sel)
        3'd4:    return 5;
        3'd5:    return 2;
        3'd6:    return 3;
        3'd7:    return 4;
        default: return 6;
    endcase
endfunction

function automatic int bytes_of(input logic [1:0] size);
    case (size)
        2'd0:    return 1;
        2'd1:    return 2;
        2'd2:    return 4;
        default: return 6;
    endcase
endfunction

// header bits 7:5 select, 4:3 size, 2:0 class
function automatic field_t model_field(input line_t l);
    field_t     f;
    logic [7:0] hdr;
    int         first;
    int         count;
    hdr   = line_byte(l, 0);
    first = start_of(hdr[7:5]);
    count = bytes_of(hdr[4:3]);
    f.raw = '0;
    for (int k = 0; k < count; k++) begin
        f.raw[8*k +: 8] = line_byte(l, first + k);
    end
    return f;
endfunction

// returns 0 for a halt, classes 4 to 7 included
function automatic bit model_result(input line_t l, output result_kind_t kind,
                                    output field_t value);
    field_t     f;
    line_t      data;
    logic [7:0] hdr;
    int         w;
    hdr   = line_byte(l, 0);
    f     = model_field(l);
    data  = model_mem[f.raw[7:0]];
    w     = int'(f.raw[9:8]);
    kind  = RES_IMM;
    value = f;
    case (hdr[2:0])
        3'd1: begin
            kind = RES_IMM;
        end
        3'd2: begin
            kind      = RES_LOAD;
            value.raw = {16'h0000, data[32*w +: 32]};
        end
        3'd3: begin
            kind               = RES_FAR;
            value.far.selector = f.raw[47:32];
            value.far.offset   = f.raw[31:0];
        end
        default: begin
            return 1'b0;
        end
    endcase
    return 1'b1;
endfunction

`endif

// File: tests/decode_tb.sv
// Decode front end testbench
`timescale 1ns/1ps
`default_nettype none

module decode_tb;
    import decode_pkg::*;
    import mem_pkg::*;

    logic         clk;
    logic         reset;
    logic         start;
    line_addr_t   start_line;
    logic         load_en;
    line_addr_t   load_addr;
    line_t        load_data;
    logic         result_valid;
    result_kind_t result_kind;
    field_t       result_value;
    logic         halted;

    result_kind_t exp_kind_q [$];
    field_t       exp_value_q [$];
    string        test_name;
    int           errors;
    int           mon_errors = 0;
    int           mon_results = 0;
    int           tests;
    int           failed;
    bit           timed_out;

    `include "decode_model.svh"

    decode_top #(
        .MEM_LINES (256)
    ) dut0 (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .start_line   (start_line),
        .load_en      (load_en),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .result_valid (result_valid),
        .result_kind  (result_kind),
        .result_value (result_value),
        .halted       (halted)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_kind(input string name, input result_kind_t exp,
                              input result_kind_t act, inout int err_count);
        if (act !== exp) begin
            err_count++;
            $display("[ERROR] %s result_kind expected %s got %s", name, exp.name(), act.name());
        end
    endtask

    task automatic check_field(input string name, input field_t exp,
                               input field_t act, inout int err_count);
        if (act.raw !== exp.raw) begin
            err_count++;
            $display("[ERROR] %s result_value expected %h got %h", name, exp.raw, act.raw);
        end
    endtask

    task automatic check_halted(input string name, input logic exp,
                                input logic act, inout int err_count);
        if (act !== exp) begin
            err_count++;
            $display("[ERROR] %s halted expected %b got %b", name, exp, act);
        end
    endtask

    // one write per cycle, called right after a falling edge
    task automatic load_line(input line_addr_t addr, input line_t data);
        load_en   = 1'b1;
        load_addr = addr;
        load_data = data;
        @(negedge clk);
        load_en = 1'b0;
        model_mem[addr] = data;
    endtask

    function automatic line_t make_insn(input logic [2:0] sel, input logic [1:0] size,
                                        input logic [2:0] cls);
        line_t l;
        l = {$urandom, $urandom, $urandom, $urandom};
        l[127:120] = {sel, size, cls};
        return l;
    endfunction

    // count random instructions and a closing halt
    task automatic write_mixed(input line_addr_t first, input int count, input bit loads_only);
        line_addr_t addr;
        logic [2:0] cls;
        addr = first;
        for (int i = 0; i < count; i++) begin
            cls = loads_only ? 3'd2 : 3'(1 + $urandom_range(0, 2));
            load_line(addr, make_insn(3'($urandom), 2'($urandom), cls));
            addr++;
        end
        load_line(addr, make_insn(3'($urandom), 2'($urandom), 3'd0));
    endtask

    task automatic run_program(input string name, input line_addr_t first);
        line_addr_t   addr;
        result_kind_t kind;
        field_t       value;
        int           err_before;
        int           count;
        int           limit;
        int           n;
        if (timed_out) begin
            return;
        end
        test_name  = name;
        err_before = errors + mon_errors;
        count      = 0;
        addr       = first;
        for (n = 0; n < 256; n++) begin
            if (!model_result(model_mem[addr], kind, value)) begin
                break;
            end
            exp_kind_q.push_back(kind);
            exp_value_q.push_back(value);
            count++;
            addr++;
        end
        start      = 1'b1;
        start_line = first;
        @(negedge clk);
        start = 1'b0;
        check_halted(name, 1'b0, halted, errors);
        limit = 50 + 30 * count;
        n     = 0;
        while (!halted && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!halted) begin
            timed_out = 1'b1;
            errors++;
            $display("test %s: halted did not rise within %0d cycles", name, limit);
        end else begin
            if (exp_kind_q.size() != 0) begin
                errors++;
                $display("test %s: %0d results missing at halt", name, exp_kind_q.size());
            end
            // halted holds until the next start
            for (int i = 0; i < 8; i++) begin
                @(negedge clk);
                check_halted(name, 1'b1, halted, errors);
            end
        end
        exp_kind_q.delete();
        exp_value_q.delete();
        tests++;
        if (errors + mon_errors == err_before) begin
            $display("test %-18s pass, %0d results", name, count);
        end else begin
            failed++;
            $display("test %-18s fail, %0d results", name, count);
        end
    endtask

    // result pulses matched in program order
    always @(negedge clk) begin
        if (result_valid) begin
            if (exp_kind_q.size() == 0) begin
                mon_errors++;
                $display("test %s: result pulse with no instruction left to match", test_name);
            end else begin
                check_kind(test_name, exp_kind_q.pop_front(), result_kind, mon_errors);
                check_field(test_name, exp_value_q.pop_front(), result_value, mon_errors);
                mon_results++;
            end
        end
    end

    initial begin
        line_addr_t addr;
        line_t      data;
        void'($urandom(32'h75129ce4));
        reset      = 1'b1;
        start      = 1'b0;
        start_line = '0;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        errors     = 0;
        tests      = 0;
        failed     = 0;
        timed_out  = 1'b0;
        test_name  = "reset";
        repeat (5) @(negedge clk);
        reset = 1'b0;

        // random background so every load reads written data
        for (int a = 0; a < 256; a++) begin
            load_line(8'(a), {$urandom, $urandom, $urandom, $urandom});
        end

        addr = 8'h10;
        for (int s = 0; s < 8; s++) begin
            for (int z = 0; z < 4; z++) begin
                load_line(addr, make_insn(3'(s), 2'(z), 3'd1));
                addr++;
            end
        end
        load_line(addr, make_insn(3'($urandom), 2'($urandom), 3'd0));
        run_program("imm_select_size", 8'h10);

        addr = 8'h40;
        for (int s = 0; s < 8; s++) begin
            load_line(addr, make_insn(3'(s), 2'd3, 3'd3));
            addr++;
        end
        load_line(addr, make_insn(3'($urandom), 2'($urandom), 3'd0));
        run_program("far_pointer", 8'h40);

        // data lines f0..f7, one word index per load
        for (int i = 0; i < 8; i++) begin
            load_line(8'(8'hf0 + i), {$urandom, $urandom, $urandom, $urandom});
        end
        addr = 8'h50;
        for (int i = 0; i < 8; i++) begin
            data = make_insn(3'(i), 2'd1, 3'd2);
            data[127 - 8*start_of(3'(i)) -: 8] = 8'(8'hf0 + i);
            data[119 - 8*start_of(3'(i)) -: 8] = {6'($urandom), 2'(i)};
            load_line(addr, data);
            addr++;
        end
        load_line(addr, make_insn(3'($urandom), 2'($urandom), 3'd0));
        run_program("load_word_index", 8'h50);

        write_mixed(8'h60, 40, 1'b0);
        run_program("random_program", 8'h60);

        write_mixed(8'h90, 12, 1'b1);
        run_program("back_to_back_loads", 8'h90);

        write_mixed(8'hb0, 6, 1'b0);
        run_program("restart_new_line", 8'hb0);

        $display("%0d tests, %0d failed, %0d results checked, %0d errors",
                 tests, failed, mon_results, errors + mon_errors);
        if (errors + mon_errors == 0 && !timed_out) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
